// ==== source/shaper_pkg.sv ====
/*
 trapezoidal shaper package
 widths, vector types, config and AXI4-Lite structs, register map
*/
`default_nettype none

package shaper_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	localparam int SAMPLE_W    = 16;
	localparam int ACC_W       = 48;
	localparam int COEF_W      = 16;
	localparam int TAP_W       = 8;
	localparam int SHIFT_W     = 5;
	localparam int AXIL_ADDR_W = 8;
	localparam int AXIL_DATA_W = 32;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [ACC_W-1:0]    acc_t;
	typedef logic        [COEF_W-1:0]   coef_t;
	typedef logic        [TAP_W-1:0]    tap_t;
	typedef logic        [SHIFT_W-1:0]  shift_t;
	typedef logic [AXIL_ADDR_W-1:0]     axil_addr_t;
	typedef logic [AXIL_DATA_W-1:0]     axil_data_t;

	// live shaper configuration
	typedef struct packed {
		tap_t   k;
		tap_t   l;
		coef_t  m1;
		shift_t norm_shift;
	} shaper_cfg_t;

	// v(n), v(n-k), v(n-l), v(n-k-l)
	typedef struct packed {
		sample_t v_n;
		sample_t v_k;
		sample_t v_l;
		sample_t v_kl;
		logic    valid;
	} kl_taps_t;

	// ----------------------------------------
	// AXI4-Lite
	// ----------------------------------------
	typedef struct packed {
		axil_addr_t                 awaddr;
		logic                       awvalid;
		axil_data_t                 wdata;
		logic [AXIL_DATA_W/8-1:0]   wstrb;
		logic                       wvalid;
		logic                       bready;
		axil_addr_t                 araddr;
		logic                       arvalid;
		logic                       rready;
	} axil_req_t;

	typedef struct packed {
		logic       awready;
		logic       wready;
		logic [1:0] bresp;
		logic       bvalid;
		logic       arready;
		axil_data_t rdata;
		logic [1:0] rresp;
		logic       rvalid;
	} axil_rsp_t;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// register offsets
	localparam axil_addr_t REG_CTRL   = 8'h00;
	localparam axil_addr_t REG_K      = 8'h04;
	localparam axil_addr_t REG_L      = 8'h08;
	localparam axil_addr_t REG_M1     = 8'h0C;
	localparam axil_addr_t REG_NORM   = 8'h10;
	localparam axil_addr_t REG_STATUS = 8'h14;

	typedef enum logic [1:0] {
		REGS_IDLE,
		REGS_WRESP,
		REGS_RDATA
	} regs_state_e;

endpackage

`default_nettype wire

// ==== source/shaper_regs.sv ====
/*
 shaper control block
 AXI4-Lite slave, config registers, run gate and sticky saturation flag
*/
`timescale 1ns/10ps
`default_nettype none

module shaper_regs
	import shaper_pkg::*;
#(
	parameter int DEPTH = 64
)
(
	input  wire         clk,
	input  wire         reset_mult,
	input  wire axil_req_t axil_req,
	output axil_rsp_t   axil_rsp,
	input  wire         enable,
	input  wire         pulse_time,
	input  wire         sat,
	output shaper_cfg_t cfg,
	output logic        run
);

	// largest legal k+l
	localparam logic [TAP_W:0] KL_LIMIT = (TAP_W+1)'(DEPTH - 1);

	regs_state_e    state;
	logic           ena_reg;
	tap_t           k_reg;
	tap_t           l_reg;
	coef_t          m1_reg;
	shift_t         norm_reg;
	logic           sat_flag;
	logic           wr_fire;
	logic           wr_err;
	axil_data_t     wr_cur;
	axil_data_t     wr_word;
	logic [TAP_W:0] k_sum;
	logic [TAP_W:0] l_sum;

	function automatic logic addr_hit(input axil_addr_t addr);
		case (addr)
			REG_CTRL, REG_K, REG_L, REG_M1, REG_NORM, REG_STATUS:
				addr_hit = 1'b1;
			default:
				addr_hit = 1'b0;
		endcase
	endfunction

	// readback view with 0 for holes
	function automatic axil_data_t reg_word(input axil_addr_t addr);
		case (addr)
			REG_CTRL:   reg_word = axil_data_t'(ena_reg);
			REG_K:      reg_word = axil_data_t'(k_reg);
			REG_L:      reg_word = axil_data_t'(l_reg);
			REG_M1:     reg_word = axil_data_t'(m1_reg);
			REG_NORM:   reg_word = axil_data_t'(norm_reg);
			REG_STATUS: reg_word = axil_data_t'(sat_flag);
			default:    reg_word = '0;
		endcase
	endfunction

	// ----------------------------------------
	// write decode
	// ----------------------------------------
	always_comb
	begin
		// write lands on the edge that closes aw/w handshake
		wr_fire = (state == REGS_IDLE) && axil_rsp.awready;
		wr_cur  = reg_word(axil_req.awaddr);
		// byte lanes merged over current contents
		for (int b = 0; b < AXIL_DATA_W/8; b++)
		begin
			wr_word[b*8 +: 8] = axil_req.wstrb[b] ? axil_req.wdata[b*8 +: 8]
				: wr_cur[b*8 +: 8];
		end
		k_sum = {1'b0, wr_word[TAP_W-1:0]} + {1'b0, l_reg};
		l_sum = {1'b0, k_reg} + {1'b0, wr_word[TAP_W-1:0]};
		// hole or k+l past the delay line
		wr_err = !addr_hit(axil_req.awaddr)
			|| ((axil_req.awaddr == REG_K) && (k_sum > KL_LIMIT))
			|| ((axil_req.awaddr == REG_L) && (l_sum > KL_LIMIT));
	end

	// ----------------------------------------
	// AXI4-Lite slave FSM
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (!reset_mult)
		begin
			state    <= REGS_IDLE;
			axil_rsp <= '0;
		end
		else
		begin
			case (state)
				REGS_IDLE:
				begin
					if (axil_rsp.awready)
					begin
						axil_rsp.awready <= 1'b0;
						axil_rsp.wready  <= 1'b0;
						axil_rsp.bvalid  <= 1'b1;
						axil_rsp.bresp   <= wr_err ? RESP_SLVERR : RESP_OKAY;
						state            <= REGS_WRESP;
					end
					else if (axil_rsp.arready)
					begin
						axil_rsp.arready <= 1'b0;
						axil_rsp.rvalid  <= 1'b1;
						axil_rsp.rdata   <= reg_word(axil_req.araddr);
						axil_rsp.rresp   <= addr_hit(axil_req.araddr) ? RESP_OKAY : RESP_SLVERR;
						state            <= REGS_RDATA;
					end
					// writes win over reads
					else if (axil_req.awvalid && axil_req.wvalid)
					begin
						axil_rsp.awready <= 1'b1;
						axil_rsp.wready  <= 1'b1;
					end
					else if (axil_req.arvalid)
					begin
						axil_rsp.arready <= 1'b1;
					end
				end
				REGS_WRESP:
				begin
					// stall until master takes it
					if (axil_req.bready)
					begin
						axil_rsp.bvalid <= 1'b0;
						state           <= REGS_IDLE;
					end
				end
				REGS_RDATA:
				begin
					if (axil_req.rready)
					begin
						axil_rsp.rvalid <= 1'b0;
						state           <= REGS_IDLE;
					end
				end
				default:
					state <= REGS_IDLE;
			endcase
		end
	end

	// shadow registers seen by AXI only
	always_ff @(posedge clk)
	begin
		if (!reset_mult)
		begin
			ena_reg  <= 1'b0;
			k_reg    <= '0;
			l_reg    <= '0;
			m1_reg   <= '0;
			norm_reg <= '0;
		end
		else if (wr_fire && !wr_err)
		begin
			case (axil_req.awaddr)
				REG_CTRL: ena_reg  <= wr_word[0];
				REG_K:    k_reg    <= wr_word[TAP_W-1:0];
				REG_L:    l_reg    <= wr_word[TAP_W-1:0];
				REG_M1:   m1_reg   <= wr_word[COEF_W-1:0];
				REG_NORM: norm_reg <= wr_word[SHIFT_W-1:0];
				default:  ;
			endcase
		end
	end

	// ----------------------------------------
	// status, gate, live config
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (!reset_mult)
			sat_flag <= 1'b0;
		else if (sat)
			sat_flag <= 1'b1;
		// write 1 to clear on the raw lane so a masked byte never clears
		else if (wr_fire && (axil_req.awaddr == REG_STATUS)
			&& axil_req.wstrb[0] && axil_req.wdata[0])
			sat_flag <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (!reset_mult)
		begin
			run <= 1'b0;
			cfg <= '0;
		end
		else
		begin
			run <= ena_reg && enable && pulse_time;
			// datapath only sees new values between windows
			if (!run)
				cfg <= '{k: k_reg, l: l_reg, m1: m1_reg, norm_shift: norm_reg};
		end
	end

	a_bvalid_hold: assert property (@(posedge clk) disable iff (!reset_mult)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid);
	a_rvalid_hold: assert property (@(posedge clk) disable iff (!reset_mult)
		axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid);

endmodule

`default_nettype wire

// ==== source/shaper_delay_line.sv ====
/*
 sample history for the trapezoidal shaper
 shifts samples in during a window and registers taps at 0, k, l, k+l
*/
`timescale 1ns/10ps
`default_nettype none

module shaper_delay_line
	import shaper_pkg::*;
#(
	parameter int DEPTH = 64
)
(
	input  wire          clk,
	input  wire          reset_mult,
	input  wire          run,
	input  wire sample_t sample_in,
	input  wire shaper_cfg_t cfg,
	output kl_taps_t     taps
);

	localparam int IDX_W = $clog2(DEPTH);

	// hist[0] newest
	sample_t        hist [DEPTH];
	logic           hist_valid;
	logic [TAP_W:0] kl_sum;
	logic [IDX_W-1:0] idx_k;
	logic [IDX_W-1:0] idx_l;
	logic [IDX_W-1:0] idx_kl;

	assign kl_sum = {1'b0, cfg.k} + {1'b0, cfg.l};
	// regs keep k+l inside the line, truncation is safe
	assign idx_k  = IDX_W'(cfg.k);
	assign idx_l  = IDX_W'(cfg.l);
	assign idx_kl = IDX_W'(kl_sum);

	always_ff @(posedge clk)
	begin
		if (!reset_mult || !run)
		begin
			// zero history at window start
			for (int i = 0; i < DEPTH; i++)
				hist[i] <= '0;
			hist_valid <= 1'b0;
			taps       <= '0;
		end
		else
		begin
			hist[0] <= sample_in;
			for (int i = 1; i < DEPTH; i++)
				hist[i] <= hist[i-1];
			hist_valid <= 1'b1;
			taps <= '{v_n: hist[0], v_k: hist[idx_k], v_l: hist[idx_l],
				v_kl: hist[idx_kl], valid: hist_valid};
		end
	end

	a_kl_in_line: assert property (@(posedge clk) disable iff (!reset_mult)
		run |-> (kl_sum < (TAP_W+1)'(DEPTH)));

endmodule

`default_nettype wire

// ==== source/shaper_kl_diff.sv ====
/*
 double difference stage
 dk and dl from the taps, then dkl = dk - dl
*/
`timescale 1ns/10ps
`default_nettype none

module shaper_kl_diff
	import shaper_pkg::*;
(
	input  wire           clk,
	input  wire           reset_mult,
	input  wire           run,
	input  wire kl_taps_t taps,
	output acc_t          dkl,
	output logic          dkl_valid
);

	acc_t dk;
	acc_t dl;
	logic d_valid;

	always_ff @(posedge clk)
	begin
		if (!reset_mult || !run)
		begin
			dk        <= '0;
			dl        <= '0;
			d_valid   <= 1'b0;
			dkl       <= '0;
			dkl_valid <= 1'b0;
		end
		else
		begin
			// ----------------------------------------
			// stage 1, sign extended tap pairs
			// ----------------------------------------
			dk      <= acc_t'(taps.v_n) - acc_t'(taps.v_k);
			dl      <= acc_t'(taps.v_l) - acc_t'(taps.v_kl);
			d_valid <= taps.valid;
			// stage 2
			// v(n) - v(n-k) - v(n-l) + v(n-k-l)
			dkl       <= dk - dl;
			dkl_valid <= d_valid;
		end
	end

endmodule

`default_nettype wire

// ==== source/shaper_pole_zero.sv ====
/*
 pole-zero correction and trapezoid accumulation
 p integrates dkl, r = p + M1*dkl, s accumulates r
*/
`timescale 1ns/10ps
`default_nettype none

module shaper_pole_zero
	import shaper_pkg::*;
(
	input  wire              clk,
	input  wire              reset_mult,
	input  wire              run,
	input  wire shaper_cfg_t cfg,
	input  wire acc_t        dkl,
	input  wire              dkl_valid,
	output acc_t             s,
	output logic             s_valid
);

	acc_t m1_ext;
	acc_t p;
	acc_t prod;
	logic p_valid;
	acc_t r;
	logic r_valid;

	// M1 is unsigned, zero extend before the signed product
	assign m1_ext = acc_t'({1'b0, cfg.m1});

	always_ff @(posedge clk)
	begin
		if (!reset_mult || !run)
		begin
			p       <= '0;
			prod    <= '0;
			p_valid <= 1'b0;
			r       <= '0;
			r_valid <= 1'b0;
			s       <= '0;
			s_valid <= 1'b0;
		end
		else
		begin
			// ----------------------------------------
			// stage 1, p(n) and M1*dkl(n) side by side
			// ----------------------------------------
			if (dkl_valid)
				p <= p + dkl;
			prod    <= dkl * m1_ext;
			p_valid <= dkl_valid;
			// stage 2
			r       <= p + prod;
			r_valid <= p_valid;
			// stage 3, everything wraps at ACC_W
			if (r_valid)
				s <= s + r;
			s_valid <= r_valid;
		end
	end

endmodule

`default_nettype wire

// ==== source/shaper_norm.sv ====
/*
 output normaliser
 rounding arithmetic shift by norm_shift, clamp to sample range
*/
`timescale 1ns/10ps
`default_nettype none

module shaper_norm
	import shaper_pkg::*;
(
	input  wire              clk,
	input  wire              reset_mult,
	input  wire              run,
	input  wire shaper_cfg_t cfg,
	input  wire acc_t        s,
	input  wire              s_valid,
	output sample_t          output_data,
	output logic             out_valid,
	output logic             sat
);

	// sample_t limits in accumulator width
	localparam acc_t SAT_HI = acc_t'(2**(SAMPLE_W-1) - 1);
	localparam acc_t SAT_LO = -SAT_HI - acc_t'(1);

	acc_t half;
	acc_t rounded;
	acc_t shifted;
	logic over;
	logic under;

	always_comb
	begin
		// half LSB of the shifted result, none for shift 0
		half    = (cfg.norm_shift == '0) ? '0 : (acc_t'(1) << (cfg.norm_shift - 1'b1));
		rounded = s + half;
		shifted = rounded >>> cfg.norm_shift;
		over    = shifted > SAT_HI;
		under   = shifted < SAT_LO;
	end

	always_ff @(posedge clk)
	begin
		if (!reset_mult || !run)
		begin
			output_data <= '0;
			out_valid   <= 1'b0;
			sat         <= 1'b0;
		end
		else
		begin
			if (over)
				output_data <= sample_t'(SAT_HI);
			else if (under)
				output_data <= sample_t'(SAT_LO);
			else
				output_data <= sample_t'(shifted);
			out_valid <= s_valid;
			// only clamped valid samples count
			sat       <= s_valid && (over || under);
		end
	end

	a_out_known: assert property (@(posedge clk) disable iff (!reset_mult)
		out_valid |-> !$isunknown(output_data));

endmodule

`default_nettype wire

// ==== source/shaper_trapezoidal.sv ====
/*
 trapezoidal pulse shaper top
 register block plus the delay, difference, pole-zero and norm pipeline
*/
`timescale 1ns/10ps
`default_nettype none

module shaper_trapezoidal
	import shaper_pkg::*;
#(
	parameter int DEPTH = 64
)
(
	input  wire            clk,
	input  wire            reset_mult,
	input  wire axil_req_t axil_req,
	output wire axil_rsp_t axil_rsp,
	input  wire            enable,
	input  wire            pulse_time,
	input  wire sample_t   sample_in,
	output wire sample_t   output_data,
	output wire            out_valid
);

	wire shaper_cfg_t cfg;
	wire              run;
	wire              sat;
	wire kl_taps_t    taps;
	wire acc_t        dkl;
	wire              dkl_valid;
	wire acc_t        s;
	wire              s_valid;

	// ----------------------------------------
	// control
	// ----------------------------------------
	shaper_regs #(.DEPTH(DEPTH)) u_shaper_regs (
		.clk        (clk),
		.reset_mult (reset_mult),
		.axil_req   (axil_req),
		.axil_rsp   (axil_rsp),
		.enable     (enable),
		.pulse_time (pulse_time),
		.sat        (sat),
		.cfg        (cfg),
		.run        (run)
	);

	// ----------------------------------------
	// datapath, 7 stages sample to output
	// ----------------------------------------
	shaper_delay_line #(.DEPTH(DEPTH)) u_shaper_delay_line (
		.clk        (clk),
		.reset_mult (reset_mult),
		.run        (run),
		.sample_in  (sample_in),
		.cfg        (cfg),
		.taps       (taps)
	);

	shaper_kl_diff u_shaper_kl_diff (
		.clk        (clk),
		.reset_mult (reset_mult),
		.run        (run),
		.taps       (taps),
		.dkl        (dkl),
		.dkl_valid  (dkl_valid)
	);

	shaper_pole_zero u_shaper_pole_zero (
		.clk        (clk),
		.reset_mult (reset_mult),
		.run        (run),
		.cfg        (cfg),
		.dkl        (dkl),
		.dkl_valid  (dkl_valid),
		.s          (s),
		.s_valid    (s_valid)
	);

	shaper_norm u_shaper_norm (
		.clk         (clk),
		.reset_mult  (reset_mult),
		.run         (run),
		.cfg         (cfg),
		.s           (s),
		.s_valid     (s_valid),
		.output_data (output_data),
		.out_valid   (out_valid),
		.sat         (sat)
	);

endmodule

`default_nettype wire

// ==== tests/tb_shaper_trapezoidal.sv ====
/*
 testbench for the trapezoidal shaper
 AXI register access, fixed and random windows, gating and saturation vs a model
*/
`timescale 1ns/10ps
`default_nettype none

module tb_shaper_trapezoidal
	import shaper_pkg::*;
();

	localparam int DEPTH = 64;
	// four random windows of 300 plus fixed windows, AXI traffic and margin
	localparam int CYCLE_LIMIT = 4000;

	logic      clk;
	logic      reset_mult;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	logic      enable;
	logic      pulse_time;
	sample_t   sample_in;
	sample_t   output_data;
	logic      out_valid;

	// model state
	int        cyc;
	int        errors;
	int        checks;
	integer    seed;
	logic      run_m;
	logic      ena_m;
	tap_t      k_m;
	tap_t      l_m;
	coef_t     m1_m;
	shift_t    sh_m;
	acc_t      p_m;
	acc_t      s_m;
	sample_t   win_q[$];
	sample_t   exp_val[$];
	int        exp_due[$];

	shaper_trapezoidal #(.DEPTH(DEPTH)) u_shaper_trapezoidal (
		.clk         (clk),
		.reset_mult  (reset_mult),
		.axil_req    (axil_req),
		.axil_rsp    (axil_rsp),
		.enable      (enable),
		.pulse_time  (pulse_time),
		.sample_in   (sample_in),
		.output_data (output_data),
		.out_valid   (out_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------
	task automatic check_sample(input sample_t got, input sample_t exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_resp(input logic [1:0] got, input logic [1:0] exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t: %s resp %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_word(input axil_data_t got, input axil_data_t exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("** Error at %0t: %s read %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		checks++;
		if (got != exp)
		begin
			errors++;
			$display("** Error at %0t: %s took %0d edges expected %0d", $time, what, got, exp);
		end
	endtask

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic sample_t hist_at(input int i);
		if (i < 0)
			return '0;
		return win_q[i];
	endfunction

	function automatic sample_t norm_model(input acc_t v, input shift_t sh);
		acc_t t;
		acc_t hi;
		acc_t lo;
		hi = 32767;
		lo = -32768;
		if (sh == 0)
			t = v;
		else
			t = (v + (acc_t'(1) <<< (int'(sh) - 1))) >>> sh;
		if (t > hi)
			return 16'sh7fff;
		if (t < lo)
			return 16'sh8000;
		return sample_t'(t);
	endfunction

	function automatic sample_t step_model(input sample_t x);
		acc_t dkl;
		int   n;
		int   kk;
		int   ll;
		kk = int'(k_m);
		ll = int'(l_m);
		win_q.push_back(x);
		n = win_q.size() - 1;
		// v(n) - v(n-k) - v(n-l) + v(n-k-l)
		dkl = acc_t'(hist_at(n)) - acc_t'(hist_at(n - kk))
			- acc_t'(hist_at(n - ll)) + acc_t'(hist_at(n - kk - ll));
		p_m = p_m + dkl;
		s_m = s_m + p_m + dkl * acc_t'(m1_m);
		return norm_model(s_m, sh_m);
	endfunction

	task automatic clear_model();
		win_q.delete();
		exp_val.delete();
		exp_due.delete();
		p_m = '0;
		s_m = '0;
	endtask

	// capture and gate tracking at every edge along with the timeout
	always @(posedge clk)
	begin
		cyc = cyc + 1;
		if (cyc >= CYCLE_LIMIT)
		begin
			$display("timeout reached after %0d cycles, the test did not finish", cyc);
			$display("TEST RESULT: FAIL");
			$finish;
		end
		else if (!reset_mult)
		begin
			run_m = 1'b0;
			clear_model();
		end
		else
		begin
			// sample taken at this edge comes out 7 edges later
			if (run_m)
			begin
				exp_val.push_back(step_model(sample_in));
				exp_due.push_back(cyc + 7);
			end
			else
				clear_model();
			run_m = ena_m && enable && pulse_time;
		end
	end

	// outputs are stable at the falling edge
	always @(negedge clk)
	begin
		if (reset_mult)
		begin
			if (out_valid)
			begin
				if (exp_due.size() == 0)
				begin
					errors++;
					$display("out_valid was high at %0t with no sample expected", $time);
				end
				else
				begin
					if (exp_due[0] != cyc)
					begin
						errors++;
						$display("output at %0t arrived on the wrong cycle", $time);
					end
					check_sample(output_data, exp_val.pop_front(), "output_data");
					void'(exp_due.pop_front());
				end
			end
			else if (exp_due.size() > 0 && exp_due[0] == cyc)
			begin
				errors++;
				$display("expected output missing at %0t", $time);
			end
		end
	end

	// ----------------------------------------
	// AXI4-Lite master
	// ----------------------------------------
	task automatic write_reg(input axil_addr_t addr, input axil_data_t data,
		output logic [1:0] resp);
		@(posedge clk);
		#1;
		axil_req.awaddr  = addr;
		axil_req.wdata   = data;
		axil_req.wstrb   = 4'hf;
		axil_req.awvalid = 1'b1;
		axil_req.wvalid  = 1'b1;
		do
		begin
			@(posedge clk);
			#1;
		end
		while (!axil_rsp.awready);
		// hold address and data through the accepting edge
		@(posedge clk);
		#1;
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		if (addr == REG_CTRL)
			ena_m = data[0];
		axil_req.bready = 1'b1;
		while (!axil_rsp.bvalid)
		begin
			@(posedge clk);
			#1;
		end
		resp = axil_rsp.bresp;
		@(posedge clk);
		#1;
		axil_req.bready = 1'b0;
	endtask

	task automatic read_reg(input axil_addr_t addr, output axil_data_t data,
		output logic [1:0] resp);
		@(posedge clk);
		#1;
		axil_req.araddr  = addr;
		axil_req.arvalid = 1'b1;
		do
		begin
			@(posedge clk);
			#1;
		end
		while (!axil_rsp.arready);
		@(posedge clk);
		#1;
		axil_req.arvalid = 1'b0;
		axil_req.rready  = 1'b1;
		while (!axil_rsp.rvalid)
		begin
			@(posedge clk);
			#1;
		end
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		@(posedge clk);
		#1;
		axil_req.rready = 1'b0;
	endtask

	task automatic write_expect(input axil_addr_t addr, input axil_data_t data,
		input logic [1:0] exp_resp);
		logic [1:0] resp;
		write_reg(addr, data, resp);
		check_resp(resp, exp_resp, "write");
	endtask

	task automatic read_expect(input axil_addr_t addr, input axil_data_t exp_data,
		input logic [1:0] exp_resp);
		axil_data_t data;
		logic [1:0] resp;
		read_reg(addr, data, resp);
		check_resp(resp, exp_resp, "read");
		check_word(data, exp_data, "read");
	endtask

	// gate must be closed here
	// l is cleared first so k never trips the limit
	task automatic load_config(input int k, input int l, input int m1, input int sh);
		write_expect(REG_L, 0, RESP_OKAY);
		write_expect(REG_K, k, RESP_OKAY);
		write_expect(REG_L, l, RESP_OKAY);
		write_expect(REG_M1, m1, RESP_OKAY);
		write_expect(REG_NORM, sh, RESP_OKAY);
		k_m  = tap_t'(k);
		l_m  = tap_t'(l);
		m1_m = coef_t'(m1);
		sh_m = shift_t'(sh);
		// let the live config follow while run is low
		repeat (2) @(posedge clk);
	endtask

	// mode 0 impulse then step, 1 random, 2 large step
	task automatic run_window(input int len, input int mode);
		sample_t x;
		for (int i = 0; i < len; i++)
		begin
			@(posedge clk);
			#1;
			enable     = 1'b1;
			pulse_time = 1'b1;
			case (mode)
				0:       x = (i == 10) ? 16'sd4000 : ((i >= 100) ? 16'sd1000 : 16'sd0);
				1:       x = sample_t'($random(seed));
				default: x = (i >= 5) ? 16'sd30000 : 16'sd0;
			endcase
			sample_in = x;
		end
		@(posedge clk);
		#1;
		enable     = 1'b0;
		pulse_time = 1'b0;
		sample_in  = '0;
		repeat (3) @(posedge clk);
	endtask

	// edges from the gate edge until out_valid equals level
	task automatic count_edges(input logic level, output int n);
		n = 0;
		do
		begin
			@(posedge clk);
			#1;
			n++;
		end
		while (out_valid != level && n < 20);
	endtask

	initial
	begin
		int kk;
		int ll;
		int n;
		seed       = 32'hfdef_95a4;
		cyc        = 0;
		errors     = 0;
		checks     = 0;
		run_m      = 1'b0;
		ena_m      = 1'b0;
		k_m        = '0;
		l_m        = '0;
		m1_m       = '0;
		sh_m       = '0;
		p_m        = '0;
		s_m        = '0;
		axil_req   = '0;
		enable     = 1'b0;
		pulse_time = 1'b0;
		sample_in  = '0;
		reset_mult = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		reset_mult = 1'b1;

		// ----------------------------------------
		// register map
		// ----------------------------------------
		write_expect(REG_K, 5, RESP_OKAY);
		write_expect(REG_L, 7, RESP_OKAY);
		write_expect(REG_M1, 32'h1234, RESP_OKAY);
		write_expect(REG_NORM, 3, RESP_OKAY);
		write_expect(REG_CTRL, 1, RESP_OKAY);
		read_expect(REG_K, 5, RESP_OKAY);
		read_expect(REG_L, 7, RESP_OKAY);
		read_expect(REG_M1, 32'h1234, RESP_OKAY);
		read_expect(REG_NORM, 3, RESP_OKAY);
		read_expect(REG_CTRL, 1, RESP_OKAY);
		read_expect(8'h20, 0, RESP_SLVERR);
		// 60 + 7 is past the delay line
		write_expect(REG_K, 60, RESP_SLVERR);
		read_expect(REG_K, 5, RESP_OKAY);
		// so is 5 + 60
		write_expect(REG_L, 60, RESP_SLVERR);
		read_expect(REG_L, 7, RESP_OKAY);
		write_expect(8'h24, 1, RESP_SLVERR);

		// fixed impulse and step
		load_config(10, 20, 50, 8);
		run_window(300, 0);

		// ----------------------------------------
		// random windows
		// ----------------------------------------
		repeat (4)
		begin
			kk = {$random(seed)} % 64;
			ll = {$random(seed)} % (64 - kk);
			load_config(kk, ll, {$random(seed)} % 256, {$random(seed)} % 21);
			run_window(300, 1);
		end

		// gating latency with a constant input
		load_config(4, 8, 20, 4);
		#1;
		sample_in = 16'sd500;
		@(posedge clk);
		#1;
		enable     = 1'b1;
		pulse_time = 1'b1;
		@(posedge clk);
		count_edges(1'b1, n);
		check_count(n, 8, "out_valid rise");
		repeat (5) @(posedge clk);
		#1;
		pulse_time = 1'b0;
		@(posedge clk);
		count_edges(1'b0, n);
		check_count(n, 1, "out_valid fall");
		pulse_time = 1'b1;
		@(posedge clk);
		count_edges(1'b1, n);
		check_count(n, 8, "out_valid second rise");
		// dropping ctrl.ena also closes the window
		write_expect(REG_CTRL, 0, RESP_OKAY);
		repeat (3) @(posedge clk);
		#1;
		enable     = 1'b0;
		pulse_time = 1'b0;
		sample_in  = '0;
		write_expect(REG_CTRL, 1, RESP_OKAY);

		// ----------------------------------------
		// saturation and sticky flag
		// ----------------------------------------
		write_expect(REG_STATUS, 1, RESP_OKAY);
		read_expect(REG_STATUS, 0, RESP_OKAY);
		load_config(5, 10, 100, 0);
		run_window(60, 2);
		read_expect(REG_STATUS, 1, RESP_OKAY);
		write_expect(REG_STATUS, 1, RESP_OKAY);
		read_expect(REG_STATUS, 0, RESP_OKAY);

		repeat (4) @(posedge clk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== shaper_trapezoidal.f ====
source/shaper_pkg.sv
source/shaper_regs.sv
source/shaper_delay_line.sv
source/shaper_kl_diff.sv
source/shaper_pole_zero.sv
source/shaper_norm.sv
source/shaper_trapezoidal.sv
tests/tb_shaper_trapezoidal.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the shaper testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal \
	--top-module tb_shaper_trapezoidal \
	-f shaper_trapezoidal.f \
	-o sim_tb
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
